// File: hdl/region_pkg.sv
/*
  Shared widths, address window, latency table and queue sizing for the
  region responder. RTL blocks and the testbench use these by scoped names.
*/
`default_nettype none

package region_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;

  localparam int unsigned NumTargets  = 4;
  // One extra source for the error path
  localparam int unsigned NumSources  = NumTargets + 1;
  localparam int unsigned TgtIdxWidth = $clog2(NumTargets);
  localparam int unsigned SrcIdxWidth = $clog2(NumSources);

  typedef logic [SrcIdxWidth-1:0] src_idx_t;

  // Window split into NumTargets equal regions
  localparam addr_t WinStart   = 16'h1000;
  localparam addr_t WinEnd     = 16'h5000;
  localparam addr_t RegionSize = addr_t'((WinEnd - WinStart) / NumTargets);

  localparam int unsigned StoreWords    = 16;
  localparam int unsigned StoreIdxWidth = $clog2(StoreWords);
  // Byte address bits below the word index
  localparam int unsigned WordLsb       = $clog2(DataWidth / 8);

  // Even targets slow, odd targets fast
  localparam int unsigned TargetLatency [NumTargets] = '{6, 2, 6, 2};

  localparam int unsigned QueueDepth    = 8;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);

endpackage

`default_nettype wire

// File: hdl/addr_decoder.sv
/*
  Request decoder. Registers each request strobe toward the target that owns
  its region, or raises an error strobe for addresses outside the window.
*/
`timescale 1ns/100ps
`default_nettype none

module addr_decoder (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i,
  input  region_pkg::addr_t                 req_addr_i,
  input  region_pkg::id_t                   req_id_i,
  input  logic                              req_we_i,
  input  region_pkg::data_t                 req_wdata_i,
  output logic [region_pkg::NumTargets-1:0] tgt_valid_o,
  output region_pkg::addr_t                 tgt_offset_o,
  output region_pkg::id_t                   tgt_id_o,
  output logic                              tgt_we_o,
  output region_pkg::data_t                 tgt_wdata_o,
  output logic                              err_valid_o,
  output region_pkg::id_t                   err_id_o
);

  logic                               in_window;
  region_pkg::addr_t                  rel_addr;
  region_pkg::addr_t                  region_num;
  logic [region_pkg::TgtIdxWidth-1:0] tgt_idx;

  assign in_window  = (req_addr_i >= region_pkg::WinStart) &&
                      (req_addr_i < region_pkg::WinEnd);
  assign rel_addr   = req_addr_i - region_pkg::WinStart;
  assign region_num = rel_addr / region_pkg::RegionSize;
  // Only meaningful inside the window
  assign tgt_idx    = region_num[region_pkg::TgtIdxWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_valid_o <= '0;
      err_valid_o <= 1'b0;
    end else begin
      tgt_valid_o <= '0;
      err_valid_o <= req_valid_i && !in_window;
      if (req_valid_i && in_window) begin
        tgt_valid_o[tgt_idx] <= 1'b1;
      end
    end
  end

  // Shared request bus, only loaded on a strobe
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      tgt_offset_o <= rel_addr % region_pkg::RegionSize;
      tgt_id_o     <= req_id_i;
      tgt_we_o     <= req_we_i;
      tgt_wdata_o  <= req_wdata_i;
      err_id_o     <= req_id_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/latency_target.sv
/*
  Latency target with a small word store. Reads and writes take effect on
  the accepted strobe; the response leaves after exactly Latency cycles.
  A new request may enter every cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module latency_target #(
  parameter int unsigned Latency = 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              valid_i,
  input  region_pkg::addr_t offset_i,
  input  region_pkg::id_t   id_i,
  input  logic              we_i,
  input  region_pkg::data_t wdata_i,
  output logic              rsp_valid_o,
  output region_pkg::id_t   rsp_id_o,
  output region_pkg::data_t rsp_rdata_o
);

  logic [region_pkg::StoreIdxWidth-1:0] word_idx;
  region_pkg::data_t                    rd_data;
  region_pkg::data_t                    store_q [region_pkg::StoreWords];

  logic [Latency-1:0] pipe_valid_q;
  region_pkg::id_t    pipe_id_q   [Latency];
  region_pkg::data_t  pipe_data_q [Latency];

  assign word_idx = offset_i[region_pkg::WordLsb +: region_pkg::StoreIdxWidth];
  // Writes answer with zero data
  assign rd_data  = we_i ? '0 : store_q[word_idx];

  // Word store
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < region_pkg::StoreWords; i++) begin
        store_q[i] <= '0;
      end
    end else if (valid_i && we_i) begin
      store_q[word_idx] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pipe_valid_q <= '0;
    end else begin
      pipe_valid_q[0] <= valid_i;
      for (int i = 1; i < Latency; i++) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pipe_id_q[0]   <= id_i;
    pipe_data_q[0] <= rd_data;
    for (int i = 1; i < Latency; i++) begin
      pipe_id_q[i]   <= pipe_id_q[i-1];
      pipe_data_q[i] <= pipe_data_q[i-1];
    end
  end

  // Last stage is the response
  assign rsp_valid_o = pipe_valid_q[Latency-1];
  assign rsp_id_o    = pipe_id_q[Latency-1];
  assign rsp_rdata_o = pipe_data_q[Latency-1];

endmodule

`default_nettype wire

// File: hdl/resp_fifo.sv
/*
  Response queue, QueueDepth entries of id, data and error flag.
  The head entry is shown while the queue is not empty. A push into a full
  queue is dropped and sets a sticky overflow flag.
*/
`timescale 1ns/100ps
`default_nettype none

module resp_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  region_pkg::id_t   push_id_i,
  input  region_pkg::data_t push_data_i,
  input  logic              push_err_i,
  input  logic              pop_i,
  output logic              empty_o,
  output region_pkg::id_t   head_id_o,
  output region_pkg::data_t head_data_o,
  output logic              head_err_o,
  output logic              overflow_o
);

  logic [region_pkg::QueuePtrWidth-1:0] wr_ptr_q;
  logic [region_pkg::QueuePtrWidth-1:0] rd_ptr_q;
  logic [region_pkg::QueuePtrWidth:0]   count_q;
  logic                                 full;
  logic                                 do_push;
  logic                                 do_pop;

  region_pkg::id_t   mem_id   [region_pkg::QueueDepth];
  region_pkg::data_t mem_data [region_pkg::QueueDepth];
  logic              mem_err  [region_pkg::QueueDepth];

  // Depth is a power of two, so the count MSB marks full
  assign full    = count_q[region_pkg::QueuePtrWidth];
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      if (push_i && full) overflow_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_id[wr_ptr_q]   <= push_id_i;
      mem_data[wr_ptr_q] <= push_data_i;
      mem_err[wr_ptr_q]  <= push_err_i;
    end
  end

  assign head_id_o   = mem_id[rd_ptr_q];
  assign head_data_o = mem_data[rd_ptr_q];
  assign head_err_o  = mem_err[rd_ptr_q];

endmodule

`default_nettype wire

// File: hdl/resp_arbiter.sv
/*
  Round-robin drain of the response queues. Each cycle one non-empty queue
  after the last one served is popped, and its head is registered onto the
  response port, so the response strobe trails the pop by one cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module resp_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic              [region_pkg::NumSources-1:0]        nonempty_i,
  input  region_pkg::id_t   [region_pkg::NumSources-1:0]        head_id_i,
  input  region_pkg::data_t [region_pkg::NumSources-1:0]        head_data_i,
  input  logic              [region_pkg::NumSources-1:0]        head_err_i,
  output logic              [region_pkg::NumSources-1:0]        pop_o,
  output logic                                                  rsp_valid_o,
  output region_pkg::id_t                                       rsp_id_o,
  output region_pkg::data_t                                     rsp_rdata_o,
  output logic                                                  rsp_err_o
);

  region_pkg::src_idx_t last_q;
  region_pkg::src_idx_t grant;
  logic                 found;

  // Search starts just after the last source served
  always_comb begin
    region_pkg::src_idx_t cand;
    found = 1'b0;
    grant = last_q;
    pop_o = '0;
    for (int k = 1; k <= region_pkg::NumSources; k++) begin
      cand = region_pkg::src_idx_t'((int'(last_q) + k) % region_pkg::NumSources);
      if (!found && nonempty_i[cand]) begin
        found       = 1'b1;
        grant       = cand;
        pop_o[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Source 0 goes first after reset
      last_q      <= region_pkg::src_idx_t'(region_pkg::NumSources - 1);
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= found;
      if (found) last_q <= grant;
    end
  end

  always_ff @(posedge clk_i) begin
    if (found) begin
      rsp_id_o    <= head_id_i[grant];
      rsp_rdata_o <= head_data_i[grant];
      rsp_err_o   <= head_err_i[grant];
    end
  end

endmodule

`default_nettype wire

// File: hdl/region_responder_top.sv
/*
  Region responder top level. Decoder, four latency targets, one response
  queue per source and the round-robin arbiter onto the response port.
  overflow_o reports any queue that ever dropped a response.
*/
`timescale 1ns/100ps
`default_nettype none

module region_responder_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  region_pkg::addr_t req_addr_i,
  input  region_pkg::id_t   req_id_i,
  input  logic              req_we_i,
  input  region_pkg::data_t req_wdata_i,
  output logic              rsp_valid_o,
  output region_pkg::id_t   rsp_id_o,
  output region_pkg::data_t rsp_rdata_o,
  output logic              rsp_err_o,
  output logic              overflow_o
);

  // Decoder to targets
  logic [region_pkg::NumTargets-1:0] tgt_valid;
  region_pkg::addr_t                 tgt_offset;
  region_pkg::id_t                   tgt_id;
  logic                              tgt_we;
  region_pkg::data_t                 tgt_wdata;
  logic                              err_valid;
  region_pkg::id_t                   err_id;

  // Sources to queues
  logic              [region_pkg::NumSources-1:0] push;
  region_pkg::id_t   [region_pkg::NumSources-1:0] push_id;
  region_pkg::data_t [region_pkg::NumSources-1:0] push_data;
  logic              [region_pkg::NumSources-1:0] push_err;

  // Queues to arbiter
  logic              [region_pkg::NumSources-1:0] empty;
  logic              [region_pkg::NumSources-1:0] pop;
  region_pkg::id_t   [region_pkg::NumSources-1:0] head_id;
  region_pkg::data_t [region_pkg::NumSources-1:0] head_data;
  logic              [region_pkg::NumSources-1:0] head_err;
  logic              [region_pkg::NumSources-1:0] overflow;

  addr_decoder addr_decoder_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_id_i     (req_id_i),
    .req_we_i     (req_we_i),
    .req_wdata_i  (req_wdata_i),
    .tgt_valid_o  (tgt_valid),
    .tgt_offset_o (tgt_offset),
    .tgt_id_o     (tgt_id),
    .tgt_we_o     (tgt_we),
    .tgt_wdata_o  (tgt_wdata),
    .err_valid_o  (err_valid),
    .err_id_o     (err_id)
  );

  for (genvar i = 0; i < region_pkg::NumTargets; i++) begin : gen_targets
    latency_target #(
      .Latency (region_pkg::TargetLatency[i])
    ) latency_target_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .valid_i     (tgt_valid[i]),
      .offset_i    (tgt_offset),
      .id_i        (tgt_id),
      .we_i        (tgt_we),
      .wdata_i     (tgt_wdata),
      .rsp_valid_o (push[i]),
      .rsp_id_o    (push_id[i]),
      .rsp_rdata_o (push_data[i])
    );
    assign push_err[i] = 1'b0;
  end

  // Error path feeds the last queue
  assign push[region_pkg::NumTargets]      = err_valid;
  assign push_id[region_pkg::NumTargets]   = err_id;
  assign push_data[region_pkg::NumTargets] = '0;
  assign push_err[region_pkg::NumTargets]  = 1'b1;

  for (genvar s = 0; s < region_pkg::NumSources; s++) begin : gen_queues
    resp_fifo resp_fifo_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .push_i      (push[s]),
      .push_id_i   (push_id[s]),
      .push_data_i (push_data[s]),
      .push_err_i  (push_err[s]),
      .pop_i       (pop[s]),
      .empty_o     (empty[s]),
      .head_id_o   (head_id[s]),
      .head_data_o (head_data[s]),
      .head_err_o  (head_err[s]),
      .overflow_o  (overflow[s])
    );
  end

  resp_arbiter resp_arbiter_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .nonempty_i  (~empty),
    .head_id_i   (head_id),
    .head_data_i (head_data),
    .head_err_i  (head_err),
    .pop_o       (pop),
    .rsp_valid_o (rsp_valid_o),
    .rsp_id_o    (rsp_id_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
  );

  assign overflow_o = |overflow;

endmodule

`default_nettype wire

// File: tests/tb_region_responder.sv
/*
  Testbench for the region responder. Issues directed and random requests,
  predicts each response with a reference model of the window decode and
  the target stores, and matches responses by id as they arrive.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_region_responder;

  localparam int NumIds     = 1 << region_pkg::IdWidth;
  localparam int NumRandom  = 200;
  localparam int NumRequests = 8 + 8 + 4 + NumRandom;
  localparam int CycleLimit = 20 * NumRequests + 200;
  localparam int WordBytes  = region_pkg::DataWidth / 8;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  region_pkg::addr_t req_addr;
  region_pkg::id_t   req_id;
  logic              req_we;
  region_pkg::data_t req_wdata;
  logic              rsp_valid;
  region_pkg::id_t   rsp_id;
  region_pkg::data_t rsp_rdata;
  logic              rsp_err;
  logic              overflow;

  int seed;
  int err_count;
  int check_count;
  int outstanding;
  int next_id;
  int cycles;

  // Reference state
  region_pkg::data_t model_store [region_pkg::NumTargets][region_pkg::StoreWords];
  logic              exp_valid [NumIds];
  region_pkg::data_t exp_data  [NumIds];
  logic              exp_err   [NumIds];
  int                exp_src   [NumIds];
  // Ids per source in issue order
  region_pkg::id_t   src_order [region_pkg::NumSources][$];

  region_responder_top region_responder_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .req_id_i    (req_id),
    .req_we_i    (req_we),
    .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_id_o    (rsp_id),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err),
    .overflow_o  (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic region_pkg::data_t model_access(input region_pkg::addr_t addr,
                                                     input logic we,
                                                     input region_pkg::data_t wdata,
                                                     output logic err, output int src);
    int rel;
    int region;
    int word;
    if (addr < region_pkg::WinStart || addr >= region_pkg::WinEnd) begin
      err = 1'b1;
      src = region_pkg::NumTargets;
      return '0;
    end
    rel    = int'(addr) - int'(region_pkg::WinStart);
    region = rel / int'(region_pkg::RegionSize);
    word   = ((rel % int'(region_pkg::RegionSize)) / WordBytes) % region_pkg::StoreWords;
    err    = 1'b0;
    src    = region;
    if (we) begin
      model_store[region][word] = wdata;
      return '0;
    end
    return model_store[region][word];
  endfunction

  function automatic region_pkg::addr_t region_addr(input int region, input int word);
    return region_pkg::addr_t'(int'(region_pkg::WinStart) +
                               region * int'(region_pkg::RegionSize) + word * WordBytes);
  endfunction

  function automatic int find_free_id();
    int cand;
    for (int k = 0; k < NumIds; k++) begin
      cand = (next_id + k) % NumIds;
      if (!exp_valid[cand]) return cand;
    end
    return -1;
  endfunction

  task automatic check_id(input string name, input region_pkg::id_t got,
                          input region_pkg::id_t exp);
    check_count++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_data(input string name, input region_pkg::data_t got,
                            input region_pkg::data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  // Caller sits 1 ns after a rising edge; returns at the same phase
  task automatic issue_request(input region_pkg::addr_t addr, input logic we,
                               input region_pkg::data_t wdata);
    int id;
    int src;
    logic err;
    region_pkg::data_t rdata;
    id = find_free_id();
    while (id < 0) begin
      req_valid = 1'b0;
      @(posedge clk);
      #1;
      id = find_free_id();
    end
    rdata          = model_access(addr, we, wdata, err, src);
    exp_valid[id]  = 1'b1;
    exp_data[id]   = rdata;
    exp_err[id]    = err;
    exp_src[id]    = src;
    src_order[src].push_back(region_pkg::id_t'(id));
    outstanding++;
    next_id        = (id + 1) % NumIds;
    req_valid = 1'b1;
    req_addr  = addr;
    req_id    = region_pkg::id_t'(id);
    req_we    = we;
    req_wdata = wdata;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic drain_responses();
    while (outstanding != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic check_response();
    int src;
    int idx;
    if (!exp_valid[rsp_id]) begin
      $display("Response with id %0d arrived while that id was not outstanding", rsp_id);
      err_count++;
    end else begin
      src = exp_src[rsp_id];
      idx = 0;
      for (int i = 0; i < src_order[src].size(); i++) begin
        if (src_order[src][i] == rsp_id) idx = i;
      end
      // Oldest id of this source must come back first
      check_id($sformatf("rsp_id_o order of source %0d", src), rsp_id, src_order[src][0]);
      src_order[src].delete(idx);
      check_data("rsp_rdata_o", rsp_rdata, exp_data[rsp_id]);
      check_err("rsp_err_o", rsp_err, exp_err[rsp_id]);
      exp_valid[rsp_id] = 1'b0;
      outstanding--;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && rsp_valid) check_response();
  end

  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    err_count++;
    $display("Timeout after %0d cycles, %0d responses never arrived", cycles, outstanding);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int unsigned rnd;
    int unsigned kind;
    region_pkg::data_t wdata;
    region_pkg::addr_t addr;
    seed        = 32'he7f1ba16;
    err_count   = 0;
    check_count = 0;
    outstanding = 0;
    next_id     = 0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_id      = '0;
    req_we      = 1'b0;
    req_wdata   = '0;
    for (int i = 0; i < NumIds; i++) exp_valid[i] = 1'b0;
    for (int r = 0; r < region_pkg::NumTargets; r++) begin
      for (int w = 0; w < region_pkg::StoreWords; w++) model_store[r][w] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Fresh stores read zero
    for (int r = 0; r < region_pkg::NumTargets; r++) begin
      issue_request(region_addr(r, 0), 1'b0, '0);
      issue_request(region_addr(r, region_pkg::StoreWords - 1), 1'b0, '0);
    end
    drain_responses();

    // Write then read back in every region
    for (int r = 0; r < region_pkg::NumTargets; r++) begin
      wdata = $random(seed);
      issue_request(region_addr(r, 5), 1'b1, wdata);
      issue_request(region_addr(r, 5), 1'b0, '0);
    end
    drain_responses();

    // Outside the window on both sides
    issue_request(region_pkg::WinStart - 16'd4, 1'b0, '0);
    issue_request(region_pkg::WinEnd, 1'b1, 32'hdead_beef);
    issue_request(16'hfffc, 1'b0, '0);
    issue_request(16'h0000, 1'b1, 32'h1234_5678);
    drain_responses();

    for (int n = 0; n < NumRandom; n++) begin
      rnd   = $random(seed);
      kind  = $random(seed);
      wdata = $random(seed);
      if (kind % 10 == 0) begin
        if (rnd[0]) begin
          addr = region_pkg::addr_t'(rnd % int'(region_pkg::WinStart));
        end else begin
          addr = region_pkg::addr_t'(int'(region_pkg::WinEnd) +
                                     rnd % (65536 - int'(region_pkg::WinEnd)));
        end
      end else begin
        addr = region_pkg::addr_t'(int'(region_pkg::WinStart) +
                                   rnd % (int'(region_pkg::WinEnd) -
                                          int'(region_pkg::WinStart)));
      end
      issue_request(addr, kind[4], wdata);
    end
    drain_responses();

    // Catch any late extra response
    repeat (20) @(posedge clk);
    if (overflow !== 1'b0) begin
      $display("Overflow flag was set although at most 16 requests were outstanding");
      err_count++;
    end
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: region_responder.f
hdl/region_pkg.sv
hdl/addr_decoder.sv
hdl/latency_target.sv
hdl/resp_fifo.sv
hdl/resp_arbiter.sv
hdl/region_responder_top.sv
tests/tb_region_responder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the region responder testbench with Verilator and run it.
# Exit status is 0 only when the simulation reports a pass.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary \
  -f region_responder.f \
  --top-module tb_region_responder \
  --Mdir obj_dir \
  -o tb_region_responder
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/tb_region_responder)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
